//--- controlUni.sv
// control unit top, decoder and exception detector
// followed by the reset-cleared output register

`timescale 1ns/100ps
`default_nettype none

`include "mipsCtrl_macros.svh"

module controlUni
(
	input logic iCLK,
	input logic rst,
	input mipsIsaPkg::opcodeT opcode,
	input mipsIsaPkg::functT funct,
	input mipsIsaPkg::fmtT fmt,
	input mipsCtrlPkg::cop0StatusT status,
	output mipsCtrlPkg::datapathCtrlT ctrl,
	output mipsCtrlPkg::cop0CtrlT cop0
);

	mipsCtrlPkg::datapathCtrlT ctrlNext;
	mipsCtrlPkg::excClassT excClass;
	mipsCtrlPkg::cop0CtrlT cop0Next;
	logic cop0WriteReq;
	logic eretReq;

	instrDecoder decoder_i
	(
		.opcode(opcode),
		.funct(funct),
		.fmt(fmt),
		.ctrl(ctrlNext),
		.excClass(excClass),
		.cop0WriteReq(cop0WriteReq),
		.eretReq(eretReq)
	);

	excDetector detector_i
	(
		.excClass(excClass),
		.cop0WriteReq(cop0WriteReq),
		.eretReq(eretReq),
		.status(status),
		.cop0(cop0Next)
	);

	// one cycle decode stage
	always_ff @(posedge iCLK)
	begin
		if (rst)
		begin
			ctrl <= '0;
			cop0 <= '0;
		end
		else
		begin
			ctrl <= ctrlNext;
			cop0 <= cop0Next;
		end
	end

	// a granted ERET must also steer the PC to the exception vector
	eretVectorA: assert property (@(posedge iCLK) disable iff (rst)
		cop0.eret |-> ctrl.pcSrc == `PCSRC_EXC)
	else
		$error("controlUni: eret without exception-vector pcSrc");

endmodule

`default_nettype wire

//--- controlUni_tb.sv
// testbench for the control unit, LFSR stimulus,
// rule-based reference model and checking assertions

`timescale 1ns/100ps
`default_nettype none

`include "mipsCtrl_macros.svh"

module controlUni_tb;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 10;
	localparam int TEST_CYCLES = 2000;
	localparam int WATCHDOG_NS = (RESET_CYCLES + TEST_CYCLES + 50) * CLK_PERIOD;

	logic clk;
	logic rst;
	mipsIsaPkg::opcodeT opcode;
	mipsIsaPkg::functT funct;
	mipsIsaPkg::fmtT fmt;
	mipsCtrlPkg::cop0StatusT status;
	mipsCtrlPkg::datapathCtrlT ctrl;
	mipsCtrlPkg::cop0CtrlT cop0;

	mipsCtrlPkg::datapathCtrlT expCtrl;
	mipsCtrlPkg::cop0CtrlT expCop0;
	logic checkOn;
	logic [31:0] lfsr;
	int errorCount;

	controlUni dut_i
	(
		.iCLK(clk),
		.rst(rst),
		.opcode(opcode),
		.funct(funct),
		.fmt(fmt),
		.status(status),
		.ctrl(ctrl),
		.cop0(cop0)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
	endfunction

	// one LFSR step per bit taken
	task automatic randBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrStep(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// {opcode, funct, fmt} of the kept instruction classes
	function automatic logic [16:0] instrFromTable(input logic [4:0] idx);
		case (idx)
			5'd0: return {`OPC_LW, 6'h00, 5'h00};
			5'd1: return {`OPC_LB, 6'h00, 5'h00};
			5'd2: return {`OPC_LHU, 6'h00, 5'h00};
			5'd3: return {`OPC_SW, 6'h00, 5'h00};
			5'd4: return {`OPC_SB, 6'h00, 5'h00};
			5'd5: return {`OPC_BEQ, 6'h00, 5'h00};
			5'd6: return {`OPC_BNE, 6'h00, 5'h00};
			5'd7: return {`OPC_J, 6'h00, 5'h00};
			5'd8: return {`OPC_JAL, 6'h00, 5'h00};
			5'd9: return {`OPC_RFMT, `FUN_JR, 5'h00};
			5'd10: return {`OPC_RFMT, `FUN_SYSCALL, 5'h00};
			5'd11: return {`OPC_RFMT, `FUN_ADD, 5'h00};
			5'd12: return {`OPC_RFMT, `FUN_SUB, 5'h00};
			5'd13: return {`OPC_RFMT, `FUN_ADDU, 5'h00};
			5'd14: return {`OPC_RFMT, `FUN_AND, 5'h00};
			5'd15: return {`OPC_RFMT, `FUN_SLL, 5'h00};
			5'd16: return {`OPC_RFMT, `FUN_MULT, 5'h00};
			5'd17: return {`OPC_RFMT, `FUN_SLT, 5'h00};
			5'd18: return {`OPC_ADDI, 6'h00, 5'h00};
			5'd19: return {`OPC_ADDIU, 6'h00, 5'h00};
			5'd20: return {`OPC_SLTI, 6'h00, 5'h00};
			5'd21: return {`OPC_ANDI, 6'h00, 5'h00};
			5'd22: return {`OPC_ORI, 6'h00, 5'h00};
			5'd23: return {`OPC_XORI, 6'h00, 5'h00};
			5'd24: return {`OPC_LUI, 6'h00, 5'h00};
			5'd25: return {`OPC_COP0, 6'h00, `FMT_MFC};
			5'd26: return {`OPC_COP0, 6'h00, `FMT_MTC};
			5'd27: return {`OPC_COP0, `FUN_ERET, `FMT_ERET};
			5'd28: return {`OPC_COP1, 6'h00, 5'h00};
			5'd29: return {`OPC_COP0, `FUN_ERET, `FMT_ERET};
			5'd30: return {`OPC_ADDI, 6'h00, 5'h00};
			default: return {`OPC_RFMT, 6'h01, 5'h00};
		endcase
	endfunction

	// reference: decoding and exception rules applied to one instruction
	task automatic predict(input mipsIsaPkg::opcodeT op, input mipsIsaPkg::functT fn,
		input mipsIsaPkg::fmtT fm, input mipsCtrlPkg::cop0StatusT st,
		output mipsCtrlPkg::datapathCtrlT c, output mipsCtrlPkg::cop0CtrlT k);
		logic isLoad, isStore, isR, rAlu, isJr, isSys, immS, immZ;
		logic mfc, mtc, eret, priv, ovfClass, known, anyInt, open;
		isLoad = op inside {`OPC_LB, `OPC_LH, `OPC_LW, `OPC_LBU, `OPC_LHU};
		isStore = op inside {`OPC_SB, `OPC_SH, `OPC_SW};
		isR = (op == `OPC_RFMT);
		rAlu = isR && (fn inside {`FUN_ADD, `FUN_SUB, `FUN_ADDU, `FUN_SUBU, `FUN_AND,
			`FUN_OR, `FUN_XOR, `FUN_NOR, `FUN_SLT, `FUN_SLTU, `FUN_SLL, `FUN_SRL,
			`FUN_SRA, `FUN_SLLV, `FUN_SRLV, `FUN_SRAV, `FUN_MFHI, `FUN_MTHI,
			`FUN_MFLO, `FUN_MTLO, `FUN_MULT, `FUN_MULTU, `FUN_DIV, `FUN_DIVU});
		isJr = isR && (fn == `FUN_JR);
		isSys = isR && (fn == `FUN_SYSCALL);
		immS = op inside {`OPC_ADDI, `OPC_ADDIU, `OPC_SLTI, `OPC_SLTIU};
		immZ = op inside {`OPC_ANDI, `OPC_ORI, `OPC_XORI};
		mfc = (op == `OPC_COP0) && (fm == `FMT_MFC);
		mtc = (op == `OPC_COP0) && (fm == `FMT_MTC);
		eret = (op == `OPC_COP0) && (fm == `FMT_ERET) && (fn == `FUN_ERET);
		priv = mfc | mtc | eret;
		ovfClass = (isR && (fn inside {`FUN_ADD, `FUN_SUB})) || (op == `OPC_ADDI);
		known = isLoad | isStore | rAlu | isJr | isSys | immS | immZ | priv
			| (op inside {`OPC_BEQ, `OPC_BNE, `OPC_J, `OPC_JAL, `OPC_LUI});
		anyInt = |st.pendingInterrupt;
		open = ~st.excLevel;

		c = '0;
		if (isLoad | isStore | immS)
			c.aluSrc = `ALUSRC_SIMM;
		if (immZ)
			c.aluSrc = `ALUSRC_ZIMM;
		if (immS | immZ)
			c.aluOp = `ALUOP_IMM;
		if (rAlu)
		begin
			c.aluOp = `ALUOP_RFMT;
			c.regDst = `REGDST_RD;
		end
		if (op == `OPC_BEQ || op == `OPC_BNE)
			c.aluOp = `ALUOP_SUB;
		c.memRead = isLoad;
		c.memWrite = isStore;
		c.regWrite = isLoad | rAlu | immS | immZ | mfc | (op == `OPC_LUI) | (op == `OPC_JAL);
		c.branchDelay = isJr | (op inside {`OPC_BEQ, `OPC_BNE, `OPC_J, `OPC_JAL});
		if (isLoad)
			c.memToReg = `MEM2REG_MEM;
		if (op == `OPC_LUI)
			c.memToReg = `MEM2REG_LUI;
		if (mfc)
			c.memToReg = `MEM2REG_COP0;
		if (op == `OPC_JAL)
		begin
			c.memToReg = `MEM2REG_PC4;
			c.regDst = `REGDST_RA;
		end
		if (op == `OPC_BEQ)
			c.pcSrc = `PCSRC_BEQ;
		if (op == `OPC_BNE)
			c.pcSrc = `PCSRC_BNE;
		if (op == `OPC_J || op == `OPC_JAL)
			c.pcSrc = `PCSRC_JUMP;
		if (isJr)
			c.pcSrc = `PCSRC_JR;
		if (isSys | eret)
			c.pcSrc = `PCSRC_EXC;

		k = '0;
		if (priv)
		begin
			k.cop0Write = mtc & ~st.userMode;
			k.eret = eret & ~st.userMode;
			k.excOccurred = st.userMode;
			k.excCode = `EXC_RI;
		end
		else if (!known)
		begin
			k.excOccurred = open;
			k.excCode = `EXC_RI;
		end
		else if (isSys)
		begin
			k.excOccurred = open;
			k.excCode = `EXC_SYS;
		end
		else if (ovfClass)
		begin
			k.excOccurred = (st.aluOverflow | anyInt) & open;
			k.excCode = st.aluOverflow ? `EXC_OV : `EXC_INT;
		end
		else
		begin
			k.excOccurred = anyInt & open;
			k.excCode = `EXC_INT;
		end
	endtask

	task automatic flagMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errorCount++;
		$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		$display("Test failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic abortWith(input string why);
		errorCount++;
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "stopping at first error");
	endtask

	// expected words, one cycle behind the inputs like the DUT
	always @(posedge clk)
	begin : modelB
		mipsCtrlPkg::datapathCtrlT c;
		mipsCtrlPkg::cop0CtrlT k;
		predict(opcode, funct, fmt, status, c, k);
		if (rst)
		begin
			expCtrl <= '0;
			expCop0 <= '0;
		end
		else
		begin
			expCtrl <= c;
			expCop0 <= k;
		end
		checkOn <= 1'b1;
	end

	resetClearA: assert property (@(posedge clk) rst |=> (ctrl == '0 && cop0 == '0))
	else
		abortWith("outputs not cleared in the cycle after a reset edge");

	ctrlA: assert property (@(posedge clk) checkOn |-> ctrl == expCtrl)
	else
		flagMismatch("ctrl", 32'($sampled(ctrl)), 32'($sampled(expCtrl)));

	grantA: assert property (@(posedge clk)
		checkOn |-> {cop0.cop0Write, cop0.eret} == {expCop0.cop0Write, expCop0.eret})
	else
		flagMismatch("cop0.{cop0Write,eret}",
			32'({$sampled(cop0.cop0Write), $sampled(cop0.eret)}),
			32'({$sampled(expCop0.cop0Write), $sampled(expCop0.eret)}));

	excA: assert property (@(posedge clk) checkOn |-> cop0.excOccurred == expCop0.excOccurred)
	else
		flagMismatch("cop0.excOccurred", 32'($sampled(cop0.excOccurred)),
			32'($sampled(expCop0.excOccurred)));

	codeA: assert property (@(posedge clk) checkOn |-> cop0.excCode == expCop0.excCode)
	else
		flagMismatch("cop0.excCode", 32'($sampled(cop0.excCode)),
			32'($sampled(expCop0.excCode)));

	initial
	begin : watchdogB
		#(WATCHDOG_NS);
		$display("watchdog expired before the test sequence ended");
		$display("Test failed");
		$fatal(1, "timeout");
	end

	initial
	begin : stimulusB
		logic [31:0] sel;
		logic [31:0] word;
		logic [31:0] bits;
		mipsCtrlPkg::cop0StatusT st;
		clk = 1'b0;
		rst = 1'b1;
		opcode = '0;
		funct = '0;
		fmt = '0;
		status = '0;
		checkOn = 1'b0;
		lfsr = 32'he70a5057;
		errorCount = 0;

		for (int cycle = 0; cycle < RESET_CYCLES + TEST_CYCLES; cycle++)
		begin
			@(posedge clk);
			if (cycle == RESET_CYCLES - 1)
				rst <= 1'b0;
			// a random word a quarter of the time
			randBits(2, sel);
			if (sel[1:0] == 2'b00)
				randBits(17, word);
			else
			begin
				randBits(5, sel);
				word = {15'h0, instrFromTable(sel[4:0])};
			end
			randBits(2, bits);
			st.excLevel = &bits[1:0];
			randBits(1, bits);
			st.userMode = bits[0];
			randBits(1, bits);
			st.aluOverflow = bits[0];
			// pending interrupts kept rare
			randBits(3, bits);
			if (bits[2:0] == 3'b000)
			begin
				randBits(8, bits);
				st.pendingInterrupt = bits[7:0];
			end
			else
				st.pendingInterrupt = '0;
			opcode <= word[16:11];
			funct <= word[10:5];
			fmt <= word[4:0];
			status <= st;
		end

		// last word is registered, then checked one edge later
		repeat (3) @(posedge clk);
		if (errorCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- excDetector.sv
// exception decision and cause code per exception class,
// privilege gating of COP0 write and ERET

`timescale 1ns/100ps
`default_nettype none

`include "mipsCtrl_macros.svh"

module excDetector
(
	input mipsCtrlPkg::excClassT excClass,
	input logic cop0WriteReq,
	input logic eretReq,
	input mipsCtrlPkg::cop0StatusT status,
	output mipsCtrlPkg::cop0CtrlT cop0
);

	logic intPending;
	logic excAllowed;

	assign intPending = |status.pendingInterrupt;
	// no nesting while already at exception level
	assign excAllowed = ~status.excLevel;

	always_comb
	begin
		cop0.cop0Write = cop0WriteReq & ~status.userMode;
		cop0.eret = eretReq & ~status.userMode;

		case (excClass)
			`EXC_CLASS_INT:
			begin
				cop0.excOccurred = intPending & excAllowed;
				cop0.excCode = `EXC_INT;
			end

			`EXC_CLASS_ALU:
			begin
				cop0.excOccurred = (status.aluOverflow | intPending) & excAllowed;
				cop0.excCode = status.aluOverflow ? `EXC_OV : `EXC_INT;
			end

			`EXC_CLASS_SYS:
			begin
				cop0.excOccurred = excAllowed;
				cop0.excCode = `EXC_SYS;
			end

			// COP0 access from user mode
			`EXC_CLASS_PRIV:
			begin
				cop0.excOccurred = status.userMode;
				cop0.excCode = `EXC_RI;
			end

			// reserved, also unused class values
			default:
			begin
				cop0.excOccurred = excAllowed;
				cop0.excCode = `EXC_RI;
			end
		endcase
	end

	always_comb
	begin
		assert (!((cop0.cop0Write || cop0.eret) && cop0.excOccurred))
		else
			$error("excDetector: COP0 grant together with exception");
		assert (cop0.excCode inside {`EXC_INT, `EXC_SYS, `EXC_RI, `EXC_OV})
		else
			$error("excDetector: undefined excCode %0h", cop0.excCode);
	end

endmodule

`default_nettype wire

//--- instrDecoder.sv
// instruction decode into the datapath control word,
// exception class and raw COP0 write and ERET requests

`timescale 1ns/100ps
`default_nettype none

`include "mipsCtrl_macros.svh"

module instrDecoder
(
	input mipsIsaPkg::opcodeT opcode,
	input mipsIsaPkg::functT funct,
	input mipsIsaPkg::fmtT fmt,
	output mipsCtrlPkg::datapathCtrlT ctrl,
	output mipsCtrlPkg::excClassT excClass,
	output logic cop0WriteReq,
	output logic eretReq
);

	always_comb
	begin
		// all inactive unless a group below claims it
		ctrl = '0;
		excClass = `EXC_CLASS_INT;
		cop0WriteReq = 1'b0;
		eretReq = 1'b0;

		case (opcode)
			`OPC_SB,
			`OPC_SH,
			`OPC_SW:
			begin
				ctrl.aluSrc = `ALUSRC_SIMM;
				ctrl.memWrite = 1'b1;
			end

			`OPC_LB,
			`OPC_LH,
			`OPC_LW,
			`OPC_LBU,
			`OPC_LHU:
			begin
				ctrl.aluSrc = `ALUSRC_SIMM;
				ctrl.memToReg = `MEM2REG_MEM;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
			end

			`OPC_BEQ,
			`OPC_BNE:
			begin
				ctrl.pcSrc = (opcode == `OPC_BEQ) ? `PCSRC_BEQ : `PCSRC_BNE;
				ctrl.aluOp = `ALUOP_SUB;
				ctrl.branchDelay = 1'b1;
			end

			`OPC_J,
			`OPC_JAL:
			begin
				ctrl.pcSrc = `PCSRC_JUMP;
				ctrl.branchDelay = 1'b1;
				// link into r31
				if (opcode == `OPC_JAL)
				begin
					ctrl.regDst = `REGDST_RA;
					ctrl.memToReg = `MEM2REG_PC4;
					ctrl.regWrite = 1'b1;
				end
			end

			`OPC_RFMT:
			begin
				case (funct)
					`FUN_JR:
					begin
						ctrl.pcSrc = `PCSRC_JR;
						ctrl.branchDelay = 1'b1;
					end

					`FUN_SYSCALL:
					begin
						ctrl.pcSrc = `PCSRC_EXC;
						excClass = `EXC_CLASS_SYS;
					end

					`FUN_ADD, `FUN_SUB,
					`FUN_SLL, `FUN_SRL, `FUN_SRA,
					`FUN_SLLV, `FUN_SRLV, `FUN_SRAV,
					`FUN_MFHI, `FUN_MTHI, `FUN_MFLO, `FUN_MTLO,
					`FUN_MULT, `FUN_MULTU, `FUN_DIV, `FUN_DIVU,
					`FUN_ADDU, `FUN_SUBU,
					`FUN_AND, `FUN_OR, `FUN_XOR, `FUN_NOR,
					`FUN_SLT, `FUN_SLTU:
					begin
						ctrl.regDst = `REGDST_RD;
						ctrl.aluOp = `ALUOP_RFMT;
						ctrl.regWrite = 1'b1;
						// only signed add/sub trap on overflow
						if (funct == `FUN_ADD || funct == `FUN_SUB)
							excClass = `EXC_CLASS_ALU;
					end

					default:
						excClass = `EXC_CLASS_RI;
				endcase
			end

			`OPC_ADDI,
			`OPC_ADDIU,
			`OPC_SLTI,
			`OPC_SLTIU:
			begin
				ctrl.aluSrc = `ALUSRC_SIMM;
				ctrl.aluOp = `ALUOP_IMM;
				ctrl.regWrite = 1'b1;
				if (opcode == `OPC_ADDI)
					excClass = `EXC_CLASS_ALU;
			end

			// logic immediates are zero extended
			`OPC_ANDI,
			`OPC_ORI,
			`OPC_XORI:
			begin
				ctrl.aluSrc = `ALUSRC_ZIMM;
				ctrl.aluOp = `ALUOP_IMM;
				ctrl.regWrite = 1'b1;
			end

			`OPC_LUI:
			begin
				ctrl.memToReg = `MEM2REG_LUI;
				ctrl.regWrite = 1'b1;
			end

			`OPC_COP0:
			begin
				excClass = `EXC_CLASS_PRIV;
				case (fmt)
					`FMT_MFC:
					begin
						ctrl.memToReg = `MEM2REG_COP0;
						ctrl.regWrite = 1'b1;
					end

					`FMT_MTC:
						cop0WriteReq = 1'b1;

					`FMT_ERET:
					begin
						if (funct == `FUN_ERET)
						begin
							eretReq = 1'b1;
							ctrl.pcSrc = `PCSRC_EXC;
						end
						else
							excClass = `EXC_CLASS_RI;
					end

					default:
						excClass = `EXC_CLASS_RI;
				endcase
			end

			// COP1 and anything undefined
			default:
				excClass = `EXC_CLASS_RI;
		endcase
	end

	always_comb
	begin
		assert (!(ctrl.memRead && ctrl.memWrite))
		else
			$error("instrDecoder: memRead and memWrite both set");
	end

endmodule

`default_nettype wire

//--- mipsCtrlPkg.sv
// datapath selector types, exception class type
// and the packed control and COP0 status structs

`default_nettype none

`include "mipsCtrl_macros.svh"

package mipsCtrlPkg;

	typedef logic [1:0] regDstSelT;
	typedef logic [1:0] aluSrcSelT;
	typedef logic [2:0] memToRegSelT;
	typedef logic [2:0] pcSrcSelT;
	typedef logic [1:0] aluOpT;

	// what kind of exception an instruction may raise
	typedef logic [2:0] excClassT;

	// integer datapath control word, 16 bits
	typedef struct packed {
		regDstSelT regDst;
		aluSrcSelT aluSrc;
		memToRegSelT memToReg;
		pcSrcSelT pcSrc;
		aluOpT aluOp;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic branchDelay;
	} datapathCtrlT;

	typedef struct packed {
		logic excLevel;
		logic userMode;
		logic aluOverflow;
		logic [`PENDING_INT_W-1:0] pendingInterrupt;
	} cop0StatusT;

	typedef struct packed {
		logic cop0Write;
		logic eret;
		logic excOccurred;
		mipsIsaPkg::excCodeT excCode;
	} cop0CtrlT;

endpackage

`default_nettype wire

//--- mipsCtrl_macros.svh
// opcode, funct and fmt values, selector encodings,
// exception classes and COP0 cause codes

`ifndef MIPS_CTRL_MACROS_SVH
`define MIPS_CTRL_MACROS_SVH

// opcodes
`define OPC_RFMT   6'h00
`define OPC_J      6'h02
`define OPC_JAL    6'h03
`define OPC_BEQ    6'h04
`define OPC_BNE    6'h05
`define OPC_ADDI   6'h08
`define OPC_ADDIU  6'h09
`define OPC_SLTI   6'h0a
`define OPC_SLTIU  6'h0b
`define OPC_ANDI   6'h0c
`define OPC_ORI    6'h0d
`define OPC_XORI   6'h0e
`define OPC_LUI    6'h0f
`define OPC_COP0   6'h10
// no FPU here, decodes as reserved
`define OPC_COP1   6'h11
`define OPC_LB     6'h20
`define OPC_LH     6'h21
`define OPC_LW     6'h23
`define OPC_LBU    6'h24
`define OPC_LHU    6'h25
`define OPC_SB     6'h28
`define OPC_SH     6'h29
`define OPC_SW     6'h2b

// R-type functs
`define FUN_SLL     6'h00
`define FUN_SRL     6'h02
`define FUN_SRA     6'h03
`define FUN_SLLV    6'h04
`define FUN_SRLV    6'h06
`define FUN_SRAV    6'h07
`define FUN_JR      6'h08
`define FUN_SYSCALL 6'h0c
`define FUN_MFHI    6'h10
`define FUN_MTHI    6'h11
`define FUN_MFLO    6'h12
`define FUN_MTLO    6'h13
`define FUN_MULT    6'h18
`define FUN_MULTU   6'h19
`define FUN_DIV     6'h1a
`define FUN_DIVU    6'h1b
`define FUN_ADD     6'h20
`define FUN_ADDU    6'h21
`define FUN_SUB     6'h22
`define FUN_SUBU    6'h23
`define FUN_AND     6'h24
`define FUN_OR      6'h25
`define FUN_XOR     6'h26
`define FUN_NOR     6'h27
`define FUN_SLT     6'h2a
`define FUN_SLTU    6'h2b
// funct of ERET under the COP0 CO format
`define FUN_ERET    6'h18

// coprocessor formats
`define FMT_MFC  5'h00
`define FMT_MTC  5'h04
`define FMT_ERET 5'h10

`define REGDST_RT 2'b00
`define REGDST_RD 2'b01
`define REGDST_RA 2'b10

`define ALUSRC_REG  2'b00
`define ALUSRC_SIMM 2'b01
`define ALUSRC_ZIMM 2'b10

`define MEM2REG_ALU  3'b000
`define MEM2REG_PC4  3'b010
`define MEM2REG_LUI  3'b011
`define MEM2REG_COP0 3'b101
`define MEM2REG_MEM  3'b110

`define PCSRC_SEQ  3'b000
`define PCSRC_BEQ  3'b001
`define PCSRC_JUMP 3'b010
`define PCSRC_JR   3'b011
`define PCSRC_EXC  3'b100
`define PCSRC_BNE  3'b101

`define ALUOP_ADD  2'b00
`define ALUOP_SUB  2'b01
`define ALUOP_RFMT 2'b10
`define ALUOP_IMM  2'b11

`define EXC_CLASS_INT  3'd0
`define EXC_CLASS_ALU  3'd1
`define EXC_CLASS_SYS  3'd2
`define EXC_CLASS_RI   3'd3
`define EXC_CLASS_PRIV 3'd4

// COP0 cause codes
`define EXC_INT 5'd0
`define EXC_SYS 5'd8
`define EXC_RI  5'd10
`define EXC_OV  5'd12

`define PENDING_INT_W 8

`endif

//--- mipsIsaPkg.sv
// instruction field types and the COP0 cause code type

`default_nettype none

package mipsIsaPkg;

	// primary opcode, bits 31:26
	typedef logic [5:0] opcodeT;

	// R-type function field, bits 5:0
	typedef logic [5:0] functT;

	// coprocessor format, shares the rs slot
	typedef logic [4:0] fmtT;

	// cause code as written into COP0
	typedef logic [4:0] excCodeT;

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module controlUni_tb -f verilog.f -o simv

./obj_dir/simv | tee sim.log

if grep -qx "Test passed" sim.log; then
	exit 0
else
	exit 1
fi

//--- verilog.f
+incdir+.
mipsIsaPkg.sv
mipsCtrlPkg.sv
instrDecoder.sv
excDetector.sv
controlUni.sv
controlUni_tb.sv
